//--- hdl/dmaPkg.sv
`default_nettype none

package dmaPkg;

	// bus and register widths, fixed by the register map
	localparam int DataWidth = 8;
	localparam int AddrWidth = 16;
	localparam int ChannelCount = 4;

	// command register bit positions
	localparam int CmdDisableBit = 2;
	localparam int CmdRotatingBit = 4;

	typedef logic [DataWidth-1:0] byteT;
	typedef logic [AddrWidth-1:0] wordT;
	typedef logic [$clog2(ChannelCount)-1:0] channelT;
	// one bit per channel: dreq, dack, status tc field
	typedef logic [ChannelCount-1:0] channelMaskT;

	// timing states, request is the wait for hlda
	typedef enum logic [2:0] {
		stateIdle,
		stateRequest,
		stateS1,
		stateS2,
		stateS4
	} dmaStateE;

	// cpu register addresses
	// channel registers: even is address, odd is count
	typedef enum logic [3:0] {
		regAddr0 = 4'd0,
		regCount0 = 4'd1,
		regAddr1 = 4'd2,
		regCount1 = 4'd3,
		regAddr2 = 4'd4,
		regCount2 = 4'd5,
		regAddr3 = 4'd6,
		regCount3 = 4'd7,
		regCommandStatus = 4'd8,
		regMode = 4'd11,
		regClearPointer = 4'd12
	} regAddrE;

	// mode register transfer type, taken from data bits 3..2
	typedef enum logic [1:0] {
		transferVerify = 2'd0,
		transferWrite = 2'd1,
		transferRead = 2'd2
	} transferTypeE;

endpackage

`default_nettype wire

//--- hdl/dmaRegisterFile.sv
`timescale 1ns/1ps
`default_nettype none

module dmaRegisterFile
(
	input wire logic busIf,
	input wire logic reset,
	input wire logic csN,
	input wire logic iorN,
	input wire logic iowN,
	input wire logic hlda,
	input wire dmaPkg::regAddrE regAddr,
	input wire dmaPkg::byteT dataIn,
	output dmaPkg::byteT cpuData,
	input wire logic advance,
	input wire dmaPkg::channelT transferChannel,
	output dmaPkg::wordT currentAddress,
	output dmaPkg::transferTypeE transferType,
	output dmaPkg::byteT commandReg,
	output logic tc
);

	logic cpuAccess;
	logic cpuWrite;
	logic cpuRead;
	logic channelReg;
	logic bytePointer;
	logic countExpired;
	dmaPkg::channelT regChannel;
	dmaPkg::wordT baseValue;
	dmaPkg::wordT writeValue;
	dmaPkg::wordT readWord;
	dmaPkg::byteT readByte;
	dmaPkg::byteT statusByte;
	dmaPkg::channelMaskT statusTc;

	// per channel programming and stepping registers
	dmaPkg::wordT baseAddr [dmaPkg::ChannelCount];
	dmaPkg::wordT currentAddr [dmaPkg::ChannelCount];
	dmaPkg::wordT baseCount [dmaPkg::ChannelCount];
	dmaPkg::wordT currentCount [dmaPkg::ChannelCount];
	dmaPkg::transferTypeE modeType [dmaPkg::ChannelCount];

	// strobe qualified cpu access, the bus is ours only while hlda is low
	assign cpuAccess = !csN && !hlda && (iorN != iowN);
	assign cpuWrite = cpuAccess && !iowN;
	assign cpuRead = cpuAccess && !iorN;

	// addresses 0..7 are channel registers, bit 0 picks count over address
	assign channelReg = !regAddr[3];
	assign regChannel = regAddr[2:1];

	// new byte merged into the programmed base value, base and current load together
	assign baseValue = regAddr[0] ? baseCount[regChannel] : baseAddr[regChannel];
	assign writeValue = bytePointer
		? {dataIn, baseValue[dmaPkg::DataWidth-1:0]}
		: {baseValue[dmaPkg::AddrWidth-1:dmaPkg::DataWidth], dataIn};

	// read back always shows the current registers
	assign readWord = regAddr[0] ? currentCount[regChannel] : currentAddr[regChannel];
	assign readByte = bytePointer
		? readWord[dmaPkg::AddrWidth-1:dmaPkg::DataWidth]
		: readWord[dmaPkg::DataWidth-1:0];
	assign statusByte = {{(dmaPkg::DataWidth - dmaPkg::ChannelCount){1'b0}}, statusTc};

	// count at zero before the decrement means this was the last transfer
	assign countExpired = advance && (currentCount[transferChannel] == '0);

	// the channel being served drives the timing block
	assign currentAddress = currentAddr[transferChannel];
	assign transferType = modeType[transferChannel];

	// byte pointer, read data latch, command and mode
	always_ff @(posedge busIf)
	begin
		if (reset)
		begin
			bytePointer <= 1'b0;
			cpuData <= '0;
			commandReg <= '0;
			for (int i = 0; i < dmaPkg::ChannelCount; i++)
			begin
				modeType[i] <= dmaPkg::transferVerify;
			end
		end
		else
		begin
			// any write to the clear address resets the pointer to low byte
			if (cpuWrite && (regAddr == dmaPkg::regClearPointer))
				bytePointer <= 1'b0;
			else if (cpuAccess && channelReg)
				bytePointer <= !bytePointer;

			// dataOut holds until the next read
			if (cpuRead)
			begin
				if (channelReg)
					cpuData <= readByte;
				else if (regAddr == dmaPkg::regCommandStatus)
					cpuData <= statusByte;
				else
					cpuData <= '0;
			end

			if (cpuWrite && (regAddr == dmaPkg::regCommandStatus))
				commandReg <= dataIn;
			// mode byte: channel in bits 1..0, transfer type in 3..2
			if (cpuWrite && (regAddr == dmaPkg::regMode))
				modeType[dataIn[1:0]] <= dmaPkg::transferTypeE'(dataIn[3:2]);
		end
	end

	// address and count registers
	// cpu writes and advance never collide, advance only comes while hlda is high
	always_ff @(posedge busIf)
	begin
		if (reset)
		begin
			for (int i = 0; i < dmaPkg::ChannelCount; i++)
			begin
				baseAddr[i] <= '0;
				currentAddr[i] <= '0;
				baseCount[i] <= '0;
				currentCount[i] <= '0;
			end
		end
		else if (cpuWrite && channelReg)
		begin
			if (regAddr[0])
			begin
				baseCount[regChannel] <= writeValue;
				currentCount[regChannel] <= writeValue;
			end
			else
			begin
				baseAddr[regChannel] <= writeValue;
				currentAddr[regChannel] <= writeValue;
			end
		end
		else if (advance)
		begin
			// step at the edge that ends S4
			currentAddr[transferChannel] <= currentAddr[transferChannel] + 1'b1;
			currentCount[transferChannel] <= currentCount[transferChannel] - 1'b1;
		end
	end

	// terminal count pulse and status bits
	always_ff @(posedge busIf)
	begin
		if (reset)
		begin
			tc <= 1'b0;
			statusTc <= '0;
		end
		else
		begin
			tc <= countExpired;
			// status read clears, a new terminal count in the same cycle wins
			if (cpuRead && (regAddr == dmaPkg::regCommandStatus))
				statusTc <= '0;
			if (countExpired)
				statusTc[transferChannel] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/dmaPriority.sv
`timescale 1ns/1ps
`default_nettype none

module dmaPriority
(
	input wire logic busIf,
	input wire logic reset,
	input wire dmaPkg::channelMaskT dreq,
	input wire logic rotating,
	input wire logic serviceDone,
	input wire dmaPkg::channelT servedChannel,
	output logic grantValid,
	output dmaPkg::channelT grantChannel
);

	// order[0] is the highest priority channel
	dmaPkg::channelT order [dmaPkg::ChannelCount];
	// order actually used by the arbiter this cycle
	dmaPkg::channelT rank [dmaPkg::ChannelCount];

	// fixed mode ignores the order register, channel 0 first
	always_comb
	begin
		for (int i = 0; i < dmaPkg::ChannelCount; i++)
		begin
			rank[i] = rotating ? order[i] : dmaPkg::channelT'(i);
		end
	end

	// scan from lowest priority up so the highest requester is assigned last
	always_comb
	begin
		grantValid = 1'b0;
		grantChannel = '0;
		for (int i = dmaPkg::ChannelCount - 1; i >= 0; i--)
		begin
			if (dreq[rank[i]])
			begin
				grantValid = 1'b1;
				grantChannel = rank[i];
			end
		end
	end

	// order stays a rotation of 0..3
	// after serving n, channel n+1 leads and n drops to last place
	always_ff @(posedge busIf)
	begin
		for (int i = 0; i < dmaPkg::ChannelCount; i++)
		begin
			// held at 0,1,2,3 outside rotating mode so a switch starts from channel 0
			if (reset || !rotating)
				order[i] <= dmaPkg::channelT'(i);
			else if (serviceDone)
				order[i] <= servedChannel + dmaPkg::channelT'(i + 1);
		end
	end

endmodule

`default_nettype wire

//--- hdl/dmaTimingControl.sv
`timescale 1ns/1ps
`default_nettype none

module dmaTimingControl
(
	input wire logic busIf,
	input wire logic reset,
	input wire logic hlda,
	input wire logic grantValid,
	input wire dmaPkg::channelT grantChannel,
	input wire dmaPkg::byteT commandReg,
	input wire dmaPkg::wordT currentAddress,
	input wire dmaPkg::transferTypeE transferType,
	output logic hrq,
	output logic aen,
	output logic adstb,
	output dmaPkg::channelMaskT dack,
	output dmaPkg::byteT addrOut,
	output dmaPkg::byteT upperAddress,
	output logic ioReadN,
	output logic ioWriteN,
	output logic memReadN,
	output logic memWriteN,
	output logic advance,
	output logic serviceDone,
	output dmaPkg::channelT transferChannel
);

	dmaPkg::dmaStateE state;
	dmaPkg::dmaStateE nextState;
	logic enabled;
	logic readPhase;
	logic writePhase;
	logic isWrite;
	logic isRead;

	// command bit 2 set disables the controller
	assign enabled = !commandReg[dmaPkg::CmdDisableBit];

	// single transfer: request, then S1 S2 S4 and back to idle
	always_comb
	begin
		nextState = state;
		case (state)
			dmaPkg::stateIdle:
			begin
				if (grantValid && enabled)
					nextState = dmaPkg::stateRequest;
			end
			// a late hlda just stalls here, dreq is still held
			dmaPkg::stateRequest:
			begin
				if (hlda)
					nextState = dmaPkg::stateS1;
			end
			dmaPkg::stateS1:
				nextState = dmaPkg::stateS2;
			dmaPkg::stateS2:
				nextState = dmaPkg::stateS4;
			dmaPkg::stateS4:
				nextState = dmaPkg::stateIdle;
			default:
				nextState = dmaPkg::stateIdle;
		endcase
	end

	always_ff @(posedge busIf)
	begin
		if (reset)
		begin
			state <= dmaPkg::stateIdle;
			transferChannel <= '0;
		end
		else
		begin
			state <= nextState;
			// channel is frozen for the whole transfer
			if ((state == dmaPkg::stateIdle) && grantValid && enabled)
				transferChannel <= grantChannel;
		end
	end

	// hold request covers the wait and all three transfer states
	assign hrq = (state != dmaPkg::stateIdle);
	assign aen = (state == dmaPkg::stateS1) || (state == dmaPkg::stateS2)
		|| (state == dmaPkg::stateS4);
	// address strobe for S1 only, upper byte goes out on the data bus
	assign adstb = (state == dmaPkg::stateS1);
	assign dack = aen ? (dmaPkg::channelMaskT'(1) << transferChannel) : '0;

	assign addrOut = aen ? currentAddress[dmaPkg::DataWidth-1:0] : '0;
	assign upperAddress = currentAddress[dmaPkg::AddrWidth-1:dmaPkg::DataWidth];

	// read strobe from S2, write strobe in S4 only
	assign readPhase = (state == dmaPkg::stateS2) || (state == dmaPkg::stateS4);
	assign writePhase = (state == dmaPkg::stateS4);

	// write moves io to memory, read moves memory to io, verify has no strobes
	assign isWrite = (transferType == dmaPkg::transferWrite);
	assign isRead = (transferType == dmaPkg::transferRead);

	assign ioReadN = !(readPhase && isWrite);
	assign memWriteN = !(writePhase && isWrite);
	assign memReadN = !(readPhase && isRead);
	assign ioWriteN = !(writePhase && isRead);

	// last cycle of the transfer steps the registers and the priority order
	assign advance = (state == dmaPkg::stateS4);
	assign serviceDone = (state == dmaPkg::stateS4);

endmodule

`default_nettype wire

//--- hdl/dma.sv
`timescale 1ns/1ps
`default_nettype none

module dma
(
	input wire logic busIf,
	input wire logic reset,
	input wire logic csN,
	input wire logic iorN,
	input wire logic iowN,
	input wire dmaPkg::regAddrE regAddr,
	input wire dmaPkg::byteT dataIn,
	output dmaPkg::byteT dataOut,
	input wire dmaPkg::channelMaskT dreq,
	output dmaPkg::channelMaskT dack,
	input wire logic hlda,
	output logic hrq,
	output logic aen,
	output logic adstb,
	output dmaPkg::byteT addrOut,
	output logic ioReadN,
	output logic ioWriteN,
	output logic memReadN,
	output logic memWriteN,
	output logic tc
);

	dmaPkg::byteT cpuData;
	dmaPkg::byteT upperAddress;
	dmaPkg::byteT commandReg;
	dmaPkg::wordT currentAddress;
	dmaPkg::transferTypeE transferType;
	dmaPkg::channelT transferChannel;
	dmaPkg::channelT grantChannel;
	logic grantValid;
	logic advance;
	logic serviceDone;

	// upper address byte borrows the data bus during adstb
	assign dataOut = adstb ? upperAddress : cpuData;

	// cpu side registers and channel stepping
	dmaRegisterFile uRegisterFile
	(
		.busIf(busIf),
		.reset(reset),
		.csN(csN),
		.iorN(iorN),
		.iowN(iowN),
		.hlda(hlda),
		.regAddr(regAddr),
		.dataIn(dataIn),
		.cpuData(cpuData),
		.advance(advance),
		.transferChannel(transferChannel),
		.currentAddress(currentAddress),
		.transferType(transferType),
		.commandReg(commandReg),
		.tc(tc)
	);

	// rotating order selected by command bit 4
	dmaPriority uPriority
	(
		.busIf(busIf),
		.reset(reset),
		.dreq(dreq),
		.rotating(commandReg[dmaPkg::CmdRotatingBit]),
		.serviceDone(serviceDone),
		.servedChannel(transferChannel),
		.grantValid(grantValid),
		.grantChannel(grantChannel)
	);

	dmaTimingControl uTimingControl
	(
		.busIf(busIf),
		.reset(reset),
		.hlda(hlda),
		.grantValid(grantValid),
		.grantChannel(grantChannel),
		.commandReg(commandReg),
		.currentAddress(currentAddress),
		.transferType(transferType),
		.hrq(hrq),
		.aen(aen),
		.adstb(adstb),
		.dack(dack),
		.addrOut(addrOut),
		.upperAddress(upperAddress),
		.ioReadN(ioReadN),
		.ioWriteN(ioWriteN),
		.memReadN(memReadN),
		.memWriteN(memWriteN),
		.advance(advance),
		.serviceDone(serviceDone),
		.transferChannel(transferChannel)
	);

endmodule

`default_nettype wire

//--- test/dma_props.sv
`timescale 1ns/1ps
`default_nettype none

module dma_props
(
	input wire logic busIf,
	input wire logic reset,
	input wire logic hlda,
	input wire logic aen,
	input wire logic adstb,
	input wire logic ioReadN,
	input wire logic ioWriteN,
	input wire dmaPkg::channelMaskT dack
);

	// failure tally, read by the testbench top
	int failures;

	// address strobe only in S1
	adstbOneCycle: assert property (@(posedge busIf) disable iff (reset) adstb |=> !adstb)
	else
	begin
		failures = failures + 1;
		$error("adstb high for more than one cycle");
	end

	// io read and io write never overlap
	ioStrobesExclusive: assert property (@(posedge busIf) disable iff (reset) ioReadN || ioWriteN)
	else
	begin
		failures = failures + 1;
		$error("ioReadN and ioWriteN low together");
	end

	dackOneHot: assert property (@(posedge busIf) disable iff (reset) $onehot0(dack))
	else
	begin
		failures = failures + 1;
		$error("dack not one-hot: 0x%h", dack);
	end

	// bus is granted before the address is enabled
	aenAfterHlda: assert property (@(posedge busIf) disable iff (reset) $rose(aen) |-> $past(hlda))
	else
	begin
		failures = failures + 1;
		$error("aen rose without hlda");
	end

endmodule

bind dmaTimingControl dma_props uProps
(
	.busIf(busIf),
	.reset(reset),
	.hlda(hlda),
	.aen(aen),
	.adstb(adstb),
	.ioReadN(ioReadN),
	.ioWriteN(ioWriteN),
	.dack(dack)
);

`default_nettype wire

//--- test/dmaChecker.sv
`timescale 1ns/1ps
`default_nettype none

module dmaChecker
(
	input wire logic busIf,
	input wire logic reset,
	input wire dmaPkg::byteT dataOut,
	input wire dmaPkg::channelMaskT dack,
	input wire logic hrq,
	input wire logic aen,
	input wire logic adstb,
	input wire dmaPkg::byteT addrOut,
	input wire logic ioReadN,
	input wire logic ioWriteN,
	input wire logic memReadN,
	input wire logic memWriteN,
	input wire logic tc,
	input wire logic idleCheck,
	input wire logic readCheck,
	input wire logic testEnd,
	input wire logic runDone,
	input wire dmaPkg::byteT expByte,
	input wire dmaPkg::channelMaskT expDack,
	input wire logic [3:0] expStrobes,
	input wire dmaPkg::wordT expAddr,
	input wire logic expTc,
	output int errorCount
);

	int testErrors;
	int testsRun;
	int testsFailed;
	logic inTransfer;
	logic sawAdstb;
	logic summaryPrinted;
	// strobes low this cycle and over the transfer: ioRead, ioWrite, memRead, memWrite
	logic [3:0] strobesLow;
	logic [3:0] strobesSeen;

	assign strobesLow = {!ioReadN, !ioWriteN, !memReadN, !memWriteN};

	task automatic compareValue(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		if (got !== expected)
		begin
			$display("[ERROR] test %0d %s: got 0x%h expected 0x%h", testsRun + 1, name, got,
				expected);
			testErrors++;
			errorCount++;
		end
	endtask

	// sampled on the rising edge, inputs move on the falling edge
	always @(posedge busIf)
	begin
		if (reset)
		begin
			inTransfer = 1'b0;
			sawAdstb = 1'b0;
			strobesSeen = '0;
			summaryPrinted = 1'b0;
		end
		else
		begin
			// quiet bus: no hold request, no transfer, strobes high
			if (idleCheck)
			begin
				compareValue("hrq", 16'(hrq), 16'h0);
				compareValue("aen", 16'(aen), 16'h0);
				compareValue("adstb", 16'(adstb), 16'h0);
				compareValue("dack", 16'(dack), 16'h0);
				compareValue("strobes", 16'({ioReadN, ioWriteN, memReadN, memWriteN}), 16'hF);
			end
			// read data is latched one edge earlier
			if (readCheck)
				compareValue("dataOut", 16'(dataOut), 16'(expByte));

			if (aen)
			begin
				// first aen cycle starts a fresh record
				if (!inTransfer)
				begin
					strobesSeen = '0;
					sawAdstb = 1'b0;
				end
				inTransfer = 1'b1;
				strobesSeen = strobesSeen | strobesLow;
				compareValue("dack", 16'(dack), 16'(expDack));
				// upper byte on the data bus, lower byte on addrOut
				if (adstb)
				begin
					sawAdstb = 1'b1;
					compareValue("dataOut", 16'(dataOut), 16'(expAddr[15:8]));
					compareValue("addrOut", 16'(addrOut), 16'(expAddr[7:0]));
				end
			end
			else if (inTransfer)
			begin
				// first idle cycle, tc pulse shows here
				inTransfer = 1'b0;
				compareValue("strobes", 16'(strobesSeen), 16'(expStrobes));
				compareValue("tc", 16'(tc), 16'(expTc));
				if (!sawAdstb)
				begin
					$display("test %0d: transfer ended without an address strobe", testsRun + 1);
					testErrors++;
					errorCount++;
				end
			end

			if (testEnd)
			begin
				testsRun++;
				if (testErrors == 0)
					$display("test %0d passed", testsRun);
				else
				begin
					$display("test %0d failed with %0d errors", testsRun, testErrors);
					testsFailed++;
				end
				testErrors = 0;
			end

			if (runDone && !summaryPrinted)
			begin
				summaryPrinted = 1'b1;
				$display("tests run %0d, passed %0d, failed %0d, errors %0d", testsRun,
					testsRun - testsFailed, testsFailed, errorCount);
			end
		end
	end

endmodule

`default_nettype wire

//--- test/dmaTb.sv
`timescale 1ns/1ps
`default_nettype none

module dmaTb;

	localparam int ClockPeriod = 4;
	localparam int ResetCycles = 4;
	localparam int MaxLines = 64;
	// budget per golden line, well above a transfer with the longest hlda wait
	localparam int CyclesPerLine = 40;

	logic busIf;
	logic reset;
	logic csN;
	logic iorN;
	logic iowN;
	dmaPkg::regAddrE regAddr;
	dmaPkg::byteT dataIn;
	dmaPkg::byteT dataOut;
	dmaPkg::channelMaskT dreq;
	dmaPkg::channelMaskT dack;
	logic hlda;
	logic hrq;
	logic aen;
	logic adstb;
	dmaPkg::byteT addrOut;
	logic ioReadN;
	logic ioWriteN;
	logic memReadN;
	logic memWriteN;
	logic tc;

	// expectations handed to the checker
	logic idleCheck;
	logic readCheck;
	logic testEnd;
	logic runDone;
	dmaPkg::byteT expByte;
	dmaPkg::channelMaskT expDack;
	logic [3:0] expStrobes;
	dmaPkg::wordT expAddr;
	logic expTc;
	int checkErrors;

	// golden line: op, reg or dreq, data or dack and strobes, address, tc
	logic [35:0] golden [MaxLines];
	int lineCount;
	int formatErrors;
	int seed;
	logic loaded;

	dma u_dut
	(
		.busIf(busIf),
		.reset(reset),
		.csN(csN),
		.iorN(iorN),
		.iowN(iowN),
		.regAddr(regAddr),
		.dataIn(dataIn),
		.dataOut(dataOut),
		.dreq(dreq),
		.dack(dack),
		.hlda(hlda),
		.hrq(hrq),
		.aen(aen),
		.adstb(adstb),
		.addrOut(addrOut),
		.ioReadN(ioReadN),
		.ioWriteN(ioWriteN),
		.memReadN(memReadN),
		.memWriteN(memWriteN),
		.tc(tc)
	);

	dmaChecker uChecker
	(
		.busIf(busIf),
		.reset(reset),
		.dataOut(dataOut),
		.dack(dack),
		.hrq(hrq),
		.aen(aen),
		.adstb(adstb),
		.addrOut(addrOut),
		.ioReadN(ioReadN),
		.ioWriteN(ioWriteN),
		.memReadN(memReadN),
		.memWriteN(memWriteN),
		.tc(tc),
		.idleCheck(idleCheck),
		.readCheck(readCheck),
		.testEnd(testEnd),
		.runDone(runDone),
		.expByte(expByte),
		.expDack(expDack),
		.expStrobes(expStrobes),
		.expAddr(expAddr),
		.expTc(expTc),
		.errorCount(checkErrors)
	);

	initial
		busIf = 1'b0;
	always #(ClockPeriod / 2) busIf = !busIf;

	task automatic writeRegister(input logic [3:0] addr, input dmaPkg::byteT data);
		@(negedge busIf);
		regAddr = dmaPkg::regAddrE'(addr);
		dataIn = data;
		csN = 1'b0;
		iowN = 1'b0;
		@(negedge busIf);
		csN = 1'b1;
		iowN = 1'b1;
	endtask

	// access at one rising edge, checker samples at the next
	task automatic readRegister(input logic [3:0] addr, input dmaPkg::byteT expected);
		@(negedge busIf);
		regAddr = dmaPkg::regAddrE'(addr);
		csN = 1'b0;
		iorN = 1'b0;
		@(negedge busIf);
		csN = 1'b1;
		iorN = 1'b1;
		expByte = expected;
		readCheck = 1'b1;
		@(negedge busIf);
		readCheck = 1'b0;
	endtask

	task automatic runTransfer(input dmaPkg::channelMaskT pattern,
		input dmaPkg::channelMaskT dackExp, input logic [3:0] strobes,
		input dmaPkg::wordT addr, input logic tcExp);
		@(negedge busIf);
		expDack = dackExp;
		expStrobes = strobes;
		expAddr = addr;
		expTc = tcExp;
		dreq = pattern;
		// device drops its request once acknowledged
		while (dack == '0)
			@(negedge busIf);
		dreq = dreq & ~dack;
		while (aen)
			@(negedge busIf);
		// other requesters withdraw between transfers
		dreq = '0;
	endtask

	task automatic pulseIdleCheck();
		@(negedge busIf);
		idleCheck = 1'b1;
		@(negedge busIf);
		idleCheck = 1'b0;
	endtask

	task automatic pulseTestEnd();
		@(negedge busIf);
		testEnd = 1'b1;
		@(negedge busIf);
		testEnd = 1'b0;
	endtask

	// cpu side answers hrq after 1 to 4 cycles, holds hlda while hrq is high
	initial
	begin
		int delay;
		hlda = 1'b0;
		forever
		begin
			@(negedge busIf);
			if (hrq && !hlda)
			begin
				delay = 1 + int'($unsigned($random(seed)) % 4);
				repeat (delay)
					@(negedge busIf);
				hlda = 1'b1;
			end
			else if (!hrq)
				hlda = 1'b0;
		end
	end

	// run length follows the golden line count
	initial
	begin
		wait (loaded);
		#((lineCount + 1) * CyclesPerLine * ClockPeriod);
		$display("watchdog expired after %0d cycles, a handshake never completed",
			(lineCount + 1) * CyclesPerLine);
		$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		logic [35:0] entry;
		reset = 1'b1;
		csN = 1'b1;
		iorN = 1'b1;
		iowN = 1'b1;
		regAddr = dmaPkg::regAddr0;
		dataIn = '0;
		dreq = '0;
		idleCheck = 1'b0;
		readCheck = 1'b0;
		testEnd = 1'b0;
		runDone = 1'b0;
		expByte = '0;
		expDack = '0;
		expStrobes = '0;
		expAddr = '0;
		expTc = 1'b0;
		formatErrors = 0;
		seed = 25;
		loaded = 1'b0;

		$readmemh("test/dma_golden.txt", golden);
		lineCount = 0;
		while ((lineCount < MaxLines) && (golden[lineCount][35:32] !== 4'hF))
			lineCount++;
		loaded = 1'b1;
		if (lineCount == 0)
		begin
			$display("golden file holds no operations");
			formatErrors++;
		end

		repeat (ResetCycles)
			@(negedge busIf);
		reset = 1'b0;

		for (int i = 0; i < lineCount; i++)
		begin
			entry = golden[i];
			case (entry[35:32])
				4'h1: writeRegister(entry[31:28], entry[27:20]);
				4'h2: readRegister(entry[31:28], entry[27:20]);
				4'h3: runTransfer(entry[31:28], entry[27:24], entry[23:20], entry[19:4], entry[0]);
				4'h4: pulseIdleCheck();
				4'h5: pulseTestEnd();
				default:
				begin
					$display("golden line %0d holds an unknown operation", i);
					formatErrors++;
				end
			endcase
		end

		// checker prints its summary, then the verdict
		@(negedge busIf);
		runDone = 1'b1;
		@(negedge busIf);
		if (u_dut.uTimingControl.uProps.failures != 0)
			$display("%0d assertion failures in the timing control",
				u_dut.uTimingControl.uProps.failures);
		if ((checkErrors == 0) && (formatErrors == 0)
			&& (u_dut.uTimingControl.uProps.failures == 0))
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
hdl/dmaPkg.sv
hdl/dmaRegisterFile.sv
hdl/dmaPriority.sv
hdl/dmaTimingControl.sv
hdl/dma.sv
test/dma_props.sv
test/dmaChecker.sv
test/dmaTb.sv

//--- Makefile
# Verilator build and run of the DMA controller testbench
TOP := dmaTb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f all.f --top-module $(TOP)
	-./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1
	@cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then exit 1; fi
	@grep -q "PASS: all tests" sim.log

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- test/dma_golden.txt
// one operation per line, nine hex digits: O R DD AAAA T
// O: 1 cpu write, 2 cpu read, 3 dma request, 4 idle check, 5 end of test, F end of file
// R: register address for write and read, dreq pattern for a request
// DD: write data or expected read byte; for a request expected dack, then strobe mask
// strobe mask bits 3..0: ioReadN, ioWriteN, memReadN, memWriteN seen low
// AAAA: expected transfer address, T: expected tc pulse after the transfer
// test 1: outputs after reset
400000000
501000000
// test 2: byte pointer, channel 1 address and count
1C0000000
123400000
121200000
223400000
221200000
130500000
1C0000000
130700000
130000000
230700000
230000000
502000000
// test 3: fixed order, program channels 0, 2 and 3 first
1C0000000
10F000000
10A500000
110100000
110000000
148100000
143C00000
16FF00000
160000000
170200000
170000000
1B0400000
1B0A00000
1B0700000
362012340
3C463C811
388900FF0
3F19A5F00
503000000
// test 4: stepped address and count, terminal count and status clear
1C0000000
20F100000
20A500000
210000000
210000000
260000000
260100000
280400000
280000000
3119A5F11
280100000
280000000
504000000
// test 5: rotating order with all four channels requesting
181000000
3F19A5F20
3F2012350
3F463C820
3F8901000
505000000
F00000000
